// File: Makefile
# Verilator build and run for the player subsystem testbench.

VERILATOR ?= verilator
TOP       ?= tb_player_top
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?=
PASS_TEXT ?= All checks passed

SOURCES := $(shell cat $(FILELIST))
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary --timing --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) $(VFLAGS)

run: compile
	-./$(BINARY) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: button_debounce.sv
////////////////////////////////////////////////////////////////////////////
// Push button debouncer
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module button_debounce #(
	parameter int settle_cycles = 360000
) (
	input  logic clk_36MHz,
	input  logic reset,
	input  logic button,
	output logic press
);

	localparam int count_width = $clog2(settle_cycles + 1);
	localparam logic [count_width-1:0] settle_last = count_width'(settle_cycles - 1);

	logic                   sync_meta; // first synchroniser stage.
	logic                   sync_level;
	logic                   stable_level; // last confirmed button level.
	logic [count_width-1:0] settle_count;

	always_ff @(posedge clk_36MHz) begin
		if (!reset) begin
			sync_meta    <= 1'b0;
			sync_level   <= 1'b0;
			stable_level <= 1'b0;
			settle_count <= '0;
			press        <= 1'b0;
		end else begin
			sync_meta  <= button;
			sync_level <= sync_meta;
			press      <= 1'b0;
			// any glitch back to the stable level restarts the count.
			if (sync_level == stable_level) begin
				settle_count <= '0;
			end else if (settle_count == settle_last) begin
				settle_count <= '0;
				stable_level <= sync_level;
				press        <= sync_level; // pulse only on a confirmed press.
			end else begin
				settle_count <= settle_count + 1'b1;
			end
		end
	end

endmodule

// File: game_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Player subsystem shared types
////////////////////////////////////////////////////////////////////////////

package game_pkg;

	// playfield geometry.
	// the playfield is 20 columns wide and 15 rows high, row 0 at the top.

	// horizontal position, 0 is the left edge.
	typedef logic [4:0] column_t; // 20 columns.

	// vertical position, the shot starts at the bottom row.
	typedef logic [3:0] row_t; // 15 rows.

	// shot sequencing.
	// idle waits for a fire press, flying climbs until it leaves row 0.
	typedef enum logic {
		shot_idle,
		shot_flying
	} shot_state_t;

endpackage

// File: player_top.sv
////////////////////////////////////////////////////////////////////////////
// Player subsystem top level
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module player_top #(
	parameter int columns       = 20,
	parameter int start_column  = 5,
	parameter int rows          = 15,
	parameter int settle_cycles = 360000, // 10 ms.
	parameter int step_cycles   = 1800000 // 50 ms.
) (
	input  logic              clk_36MHz,
	input  logic              reset,
	input  logic              enable,
	input  logic              left_button,
	input  logic              right_button,
	input  logic              fire_button,
	output game_pkg::column_t ship_x,
	output logic              shot_active,
	output game_pkg::column_t shot_x,
	output game_pkg::row_t    shot_row
);

	logic left_debounced; // one cycle press strobes.
	logic right_debounced;
	logic fire_debounced;

	button_debounce #(.settle_cycles(settle_cycles)) left_debounce (
		.clk_36MHz (clk_36MHz),
		.reset     (reset),
		.button    (left_button),
		.press     (left_debounced)
	);

	button_debounce #(.settle_cycles(settle_cycles)) right_debounce (
		.clk_36MHz (clk_36MHz),
		.reset     (reset),
		.button    (right_button),
		.press     (right_debounced)
	);

	button_debounce #(.settle_cycles(settle_cycles)) fire_debounce (
		.clk_36MHz (clk_36MHz),
		.reset     (reset),
		.button    (fire_button),
		.press     (fire_debounced)
	);

	ship #(
		.columns      (columns),
		.start_column (start_column)
	) ship (
		.clk_36MHz       (clk_36MHz),
		.reset           (reset),
		.enable          (enable),
		.left_debounced  (left_debounced),
		.right_debounced (right_debounced),
		.ship_x          (ship_x)
	);

	// the shot launches from the registered ship column.
	ship_shot #(
		.rows        (rows),
		.step_cycles (step_cycles)
	) ship_shot (
		.clk_36MHz      (clk_36MHz),
		.reset          (reset),
		.enable         (enable),
		.fire_debounced (fire_debounced),
		.ship_x         (ship_x),
		.shot_active    (shot_active),
		.shot_x         (shot_x),
		.shot_row       (shot_row)
	);

endmodule

// File: project.f
game_pkg.sv
button_debounce.sv
ship.sv
ship_shot.sv
player_top.sv
tb_clock.sv
tb_checker.sv
tb_player_top.sv

// File: ship.sv
////////////////////////////////////////////////////////////////////////////
// Ship column register
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module ship #(
	parameter int columns      = 20,
	parameter int start_column = 5
) (
	input  logic              clk_36MHz,
	input  logic              reset,
	input  logic              enable,
	input  logic              left_debounced,
	input  logic              right_debounced,
	output game_pkg::column_t ship_x
);

	import game_pkg::*;

	localparam column_t left_limit  = '0;
	localparam column_t right_limit = column_t'(columns - 1);
	localparam column_t home_column = column_t'(start_column);

	column_t next_x;

	// one column per accepted strobe, left has priority.
	always_comb begin
		next_x = ship_x;
		if (enable) begin
			if (left_debounced) begin
				if (ship_x != left_limit) begin
					next_x = ship_x - 1'b1;
				end
			end else if (right_debounced) begin
				if (ship_x != right_limit) begin
					next_x = ship_x + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk_36MHz) begin
		if (!reset) begin
			ship_x <= home_column;
		end else begin
			ship_x <= next_x;
		end
	end

endmodule

// File: ship_shot.sv
////////////////////////////////////////////////////////////////////////////
// Single player shot
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module ship_shot #(
	parameter int rows        = 15,
	parameter int step_cycles = 1800000
) (
	input  logic              clk_36MHz,
	input  logic              reset,
	input  logic              enable,
	input  logic              fire_debounced,
	input  game_pkg::column_t ship_x,
	output logic              shot_active,
	output game_pkg::column_t shot_x,
	output game_pkg::row_t    shot_row
);

	import game_pkg::*;

	localparam int step_width = $clog2(step_cycles + 1);
	localparam logic [step_width-1:0] step_last = step_width'(step_cycles - 1);
	localparam row_t bottom_row = row_t'(rows - 1);

	shot_state_t           state;
	logic [step_width-1:0] step_count;
	logic                  launch;
	logic                  step_done; // end of one step interval.

	// a fire press during flight is dropped.
	assign launch      = enable && fire_debounced && (state == shot_idle);
	assign step_done   = enable && (state == shot_flying) && (step_count == step_last);
	assign shot_active = (state == shot_flying);

	always_ff @(posedge clk_36MHz) begin
		if (!reset) begin
			state      <= shot_idle;
			step_count <= '0;
		end else begin
			case (state)
				shot_idle: begin
					step_count <= '0;
					if (launch) begin
						state <= shot_flying;
					end
				end
				shot_flying: begin
					if (step_done) begin
						step_count <= '0;
						// one more interval is spent on row 0 before it leaves.
						if (shot_row == '0) begin
							state <= shot_idle;
						end
					end else if (enable) begin
						step_count <= step_count + 1'b1;
					end
				end
				default: begin
					state      <= shot_idle;
					step_count <= '0;
				end
			endcase
		end
	end

	// launch column is taken once, the shot ignores later ship moves.
	always_ff @(posedge clk_36MHz) begin
		if (launch) begin
			shot_x   <= ship_x;
			shot_row <= bottom_row;
		end else if (step_done && shot_row != '0) begin
			shot_row <= shot_row - 1'b1; // climb one row.
		end
	end

endmodule

// File: tb_checker.sv
////////////////////////////////////////////////////////////////////////////
// Player subsystem reference model and checks
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module tb_checker #(
	parameter int columns      = 20,
	parameter int start_column = 5,
	parameter int rows         = 15,
	parameter int step_cycles  = 16
) (
	input  logic              clk_36MHz,
	input  logic              reset,
	input  logic              enable,
	input  logic              check_point,
	input  logic [3:0]        action,
	input  game_pkg::column_t ship_x,
	input  logic              shot_active,
	input  game_pkg::column_t shot_x,
	input  game_pkg::row_t    shot_row,
	output int                error_count,
	output int                check_count
);

	import game_pkg::*;

	localparam logic [3:0] act_none         = 4'd0;
	localparam logic [3:0] act_reset        = 4'd1;
	localparam logic [3:0] act_left         = 4'd2;
	localparam logic [3:0] act_right        = 4'd3;
	localparam logic [3:0] act_both         = 4'd4;
	localparam logic [3:0] act_fire         = 4'd5;
	localparam logic [3:0] act_bounce_left  = 4'd7;
	localparam logic [3:0] act_bounce_right = 4'd8;

	int         model_x;
	int         shot_column;
	int         flight_cycles; // enabled cycles since launch.
	logic       was_active;
	logic       idle_at_fire;
	logic       launched;
	logic [3:0] last_action;

	task automatic compare_value(input string what, input int actual, input int expected);
		check_count++;
		if (actual != expected) begin
			error_count++;
			$display("Mismatch at %0t: %s is %0d, expected %0d", $time, what, actual, expected);
		end
	endtask

	task automatic report_failure(input string text);
		error_count++;
		$display("Error at %0t: %s", $time, text);
	endtask

	// the row drops once per step_cycles enabled cycles.
	task automatic follow_shot();
		if (shot_active && !was_active) begin
			if (last_action != act_fire || !enable) begin
				report_failure("shot launched without an accepted fire press");
			end
			compare_value("launch shot_x", int'(shot_x), model_x);
			compare_value("launch shot_row", int'(shot_row), rows - 1);
			shot_column   = model_x;
			flight_cycles = 0;
			launched      = 1'b1;
		end
		if (shot_active) begin
			compare_value("shot_x", int'(shot_x), shot_column);
			compare_value("shot_row", int'(shot_row), rows - 1 - flight_cycles / step_cycles);
			if (enable) begin
				flight_cycles++;
			end
			if (flight_cycles == rows * step_cycles + 1) begin
				report_failure("shot still active after its full flight time");
			end
		end else if (was_active) begin
			compare_value("enabled flight cycles", flight_cycles, rows * step_cycles);
		end
		was_active = shot_active;
	endtask

	task automatic apply_action();
		case (action)
			act_reset: begin
				compare_value("shot_active after reset", int'(shot_active), 0);
			end
			act_left, act_both, act_bounce_left: begin
				if (enable && model_x > 0) begin
					model_x--; // left wins over right.
				end
			end
			act_right, act_bounce_right: begin
				if (enable && model_x < columns - 1) begin
					model_x++;
				end
			end
			act_fire: begin
				if (enable && idle_at_fire && !launched) begin
					report_failure("fire press with no shot active did not launch a shot");
				end
			end
			default: begin
			end
		endcase
		compare_value("ship_x", int'(ship_x), model_x);
	endtask

	always @(posedge clk_36MHz) begin
		if (!reset) begin
			model_x       = start_column;
			shot_column   = 0;
			flight_cycles = 0;
			was_active    = 1'b0;
			idle_at_fire  = 1'b0;
			launched      = 1'b0;
			last_action   = act_none;
			error_count   = 0;
			check_count   = 0;
		end else begin
			if (action == act_fire && last_action != act_fire) begin
				idle_at_fire = !shot_active; // this press must launch.
				launched     = 1'b0;
			end
			last_action = action;
			follow_shot();
			if (check_point) begin
				apply_action();
			end
		end
	end

endmodule

// File: tb_clock.sv
////////////////////////////////////////////////////////////////////////////
// Testbench clock and reset
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module tb_clock #(
	parameter int period       = 20,
	parameter int reset_cycles = 4
) (
	output logic clk_36MHz,
	output logic reset
);

	initial begin
		clk_36MHz = 1'b0;
		forever #(period / 2) clk_36MHz = ~clk_36MHz;
	end

	initial begin
		reset = 1'b0; // active low.
		repeat (reset_cycles) @(posedge clk_36MHz);
		@(negedge clk_36MHz);
		reset = 1'b1;
	end

endmodule

// File: tb_player_top.sv
////////////////////////////////////////////////////////////////////////////
// Player subsystem testbench
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module tb_player_top;

	import game_pkg::*;

	localparam int settle_cycles   = 8;
	localparam int step_cycles     = 16;
	localparam int rows            = 15;
	localparam int action_count    = 60;
	localparam int hold_cycles     = 3 * settle_cycles;
	localparam int watchdog_cycles = action_count * (6 * settle_cycles + 8)
		+ 2 * rows * step_cycles;

	localparam logic [3:0] act_none         = 4'd0;
	localparam logic [3:0] act_reset        = 4'd1;
	localparam logic [3:0] act_left         = 4'd2;
	localparam logic [3:0] act_right        = 4'd3;
	localparam logic [3:0] act_both         = 4'd4;
	localparam logic [3:0] act_fire         = 4'd5;
	localparam logic [3:0] act_bounce_drop  = 4'd6;
	localparam logic [3:0] act_bounce_left  = 4'd7;
	localparam logic [3:0] act_bounce_right = 4'd8;
	localparam logic [3:0] act_enable       = 4'd9;

	logic       clk_36MHz;
	logic       reset;
	logic       enable;
	logic       left_button;
	logic       right_button;
	logic       fire_button;
	column_t    ship_x;
	logic       shot_active;
	column_t    shot_x;
	row_t       shot_row;
	logic       check_point;
	logic [3:0] action;
	int         error_count;
	int         check_count;
	integer     seed;

	tb_clock #(.period(20), .reset_cycles(4)) clock_gen (
		.clk_36MHz (clk_36MHz),
		.reset     (reset)
	);

	player_top #(
		.settle_cycles (settle_cycles),
		.step_cycles   (step_cycles)
	) uut (
		.clk_36MHz    (clk_36MHz),
		.reset        (reset),
		.enable       (enable),
		.left_button  (left_button),
		.right_button (right_button),
		.fire_button  (fire_button),
		.ship_x       (ship_x),
		.shot_active  (shot_active),
		.shot_x       (shot_x),
		.shot_row     (shot_row)
	);

	tb_checker #(.rows(rows), .step_cycles(step_cycles)) model_check (
		.clk_36MHz   (clk_36MHz),
		.reset       (reset),
		.enable      (enable),
		.check_point (check_point),
		.action      (action),
		.ship_x      (ship_x),
		.shot_active (shot_active),
		.shot_x      (shot_x),
		.shot_row    (shot_row),
		.error_count (error_count),
		.check_count (check_count)
	);

	task automatic wait_cycles(input int count);
		repeat (count) @(negedge clk_36MHz);
	endtask

	task automatic press_buttons(input logic left_level, input logic right_level,
		input logic fire_level);
		left_button  = left_level;
		right_button = right_level;
		fire_button  = fire_level;
		wait_cycles(hold_cycles);
		left_button  = 1'b0;
		right_button = 1'b0;
		fire_button  = 1'b0;
		wait_cycles(hold_cycles);
	endtask

	task automatic drive_move(input logic use_right, input logic level);
		if (use_right) begin
			right_button = level;
		end else begin
			left_button = level;
		end
	endtask

	// highs stay shorter than settle_cycles, so only a settled level counts.
	task automatic bounce_burst(input logic use_right, input logic settles);
		repeat (2) begin
			drive_move(use_right, 1'b1);
			wait_cycles(3);
			drive_move(use_right, 1'b0);
			wait_cycles(1);
		end
		if (settles) begin
			drive_move(use_right, 1'b1);
			wait_cycles(hold_cycles);
			drive_move(use_right, 1'b0);
		end
		wait_cycles(hold_cycles);
	endtask

	task automatic signal_check_point();
		check_point = 1'b1;
		wait_cycles(1);
		check_point = 1'b0;
		action      = act_none;
		wait_cycles(1);
	endtask

	task automatic run_action(input int choice);
		logic [31:0] pick;
		pick = $random(seed);
		case (choice)
			0: begin
				action = act_left;
				press_buttons(1'b1, 1'b0, 1'b0);
			end
			1: begin
				action = act_right;
				press_buttons(1'b0, 1'b1, 1'b0);
			end
			2: begin
				action = act_both;
				press_buttons(1'b1, 1'b1, 1'b0);
			end
			3: begin
				action = act_fire;
				press_buttons(1'b0, 1'b0, 1'b1);
			end
			4: begin
				if (!pick[1]) begin
					action = act_bounce_drop;
				end else begin
					action = pick[0] ? act_bounce_right : act_bounce_left;
				end
				bounce_burst(pick[0], pick[1]);
			end
			default: begin
				action = act_enable;
				enable = ~enable; // pause or resume the game.
				wait_cycles(4);
			end
		endcase
		signal_check_point();
	endtask

	initial begin
		seed         = 32'h7c3d;
		enable       = 1'b1;
		left_button  = 1'b0;
		right_button = 1'b0;
		fire_button  = 1'b0;
		check_point  = 1'b0;
		action       = act_none;
		@(posedge reset);
		action = act_reset;
		signal_check_point();
		repeat (action_count) begin
			run_action(int'($unsigned($random(seed)) % 6));
		end
		enable = 1'b1; // let the last shot land.
		while (shot_active) begin
			wait_cycles(1);
		end
		wait_cycles(4);
		$display("checks %0d, errors %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

	initial begin
		repeat (watchdog_cycles) @(posedge clk_36MHz);
		$display("Timed out after %0d cycles, checks %0d, errors %0d",
			watchdog_cycles, check_count, error_count);
		$display("Checks failed");
		$finish;
	end

endmodule
